// ==== rtl/board_pkg.sv ====
// Shared widths, joystick bit positions and reset FSM type
// for the player-input and reset section of the board wrapper
package board_pkg;

    localparam int NUM_PLAYERS   = 2;   // Joystick channels
    localparam int BUTTON_OFFSET = 0;   // Extra fire buttons before start

    // Button positions in the raw board word
    localparam int START1_BIT = 6 + BUTTON_OFFSET;
    localparam int START2_BIT = 7 + BUTTON_OFFSET;
    localparam int COIN_BIT   = 8 + BUTTON_OFFSET;
    localparam int PAUSE_BIT  = 9 + BUTTON_OFFSET;

    // Game side sees active-low controls
    localparam logic INVERT_INPUTS = 1'b1;

    // Both hold times are 2**RST_CNT_W cycles
    localparam int RST_CNT_W = 8;

    localparam int NUM_GFX_LAYERS = 4;

    localparam int BOARD_JOY_W = 16;
    localparam int GAME_JOY_W  = 10;

    typedef logic [BOARD_JOY_W-1:0]    board_joy_t;   // Raw word from the board
    typedef logic [GAME_JOY_W-1:0]     game_joy_t;    // Word handed to the game
    typedef logic [1:0]                player_pair_t; // One bit per player or start
    typedef logic [NUM_GFX_LAYERS-1:0] gfx_mask_t;    // Layer enables

    // Reset sequencing
    typedef enum logic [1:0] {
        POWER_HOLD,
        GAME_HOLD,
        RUNNING
    } reset_state_t;

endpackage

// ==== rtl/board_input_capture.sv ====
`timescale 1ns/10ps

// Two-flop synchronizers for board joysticks and key levels
// Rising-edge pulses for pause, reset and graphics-layer keys
module board_input_capture (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  board_pkg::board_joy_t  board_joystick1,
    input  board_pkg::board_joy_t  board_joystick2,
    input  logic                   key_pause,
    input  logic                   key_reset,
    input  logic                   key_service,
    input  board_pkg::gfx_mask_t   key_gfx,
    output board_pkg::board_joy_t  joy_sync [board_pkg::NUM_PLAYERS],
    output logic                   service_sync,
    output logic                   key_pause_rise,
    output logic                   key_reset_rise,
    output board_pkg::gfx_mask_t   key_gfx_rise
);
    import board_pkg::*;

    board_joy_t joy_in   [NUM_PLAYERS];
    board_joy_t joy_meta [NUM_PLAYERS];

    logic [2:0] ctl_meta, ctl_sync;  // {service, reset, pause}
    logic [1:0] ctl_last;            // {reset, pause}
    gfx_mask_t  gfx_meta, gfx_sync, gfx_last;

    assign joy_in[0] = board_joystick1;
    assign joy_in[1] = board_joystick2;

    // Joystick synchronizers
    always_ff @(posedge clk_sys) begin
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            joy_meta[i] <= joy_in[i];
            joy_sync[i] <= joy_meta[i];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            ctl_meta <= '0;
            ctl_sync <= '0;
            ctl_last <= '0;
            gfx_meta <= '0;
            gfx_sync <= '0;
            gfx_last <= '0;
        end else begin
            ctl_meta <= {key_service, key_reset, key_pause};
            ctl_sync <= ctl_meta;
            ctl_last <= ctl_sync[1:0];  // Previous level for edges
            gfx_meta <= key_gfx;
            gfx_sync <= gfx_meta;
            gfx_last <= gfx_sync;
        end
    end

    assign service_sync   = ctl_sync[2];
    assign key_pause_rise = ctl_sync[0] & ~ctl_last[0];
    assign key_reset_rise = ctl_sync[1] & ~ctl_last[1];
    assign key_gfx_rise   = gfx_sync & ~gfx_last;  // One pulse per layer key

endmodule

// ==== rtl/player_port.sv ====
`timescale 1ns/10ps

// One player's joystick path
// Optional rotation of the directions, inversion and button extraction
module player_port (
    input  logic                     clk_sys,
    input  logic                     rst,
    input  logic                     rot_control,
    input  board_pkg::board_joy_t    joy_sync,
    output board_pkg::game_joy_t     game_joystick,
    output board_pkg::player_pair_t  start_raw,
    output logic                     coin_raw,
    output logic                     pause_rise
);
    import board_pkg::*;

    game_joy_t joy_low;
    game_joy_t joy_rot;
    logic      pause_last;

    assign joy_low = joy_sync[GAME_JOY_W-1:0];

    // Quarter turn of the four directions for vertical cabinets
    always_comb begin
        if (rot_control) begin
            joy_rot = {joy_low[GAME_JOY_W-1:4], joy_low[0], joy_low[1], joy_low[3], joy_low[2]};
        end else begin
            joy_rot = joy_low;
        end
    end

    always_ff @(posedge clk_sys) begin
        game_joystick <= joy_rot ^ {GAME_JOY_W{INVERT_INPUTS}};
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            pause_last <= 1'b0;
        end else begin
            pause_last <= joy_sync[PAUSE_BIT];
        end
    end

    assign start_raw  = {joy_sync[START2_BIT], joy_sync[START1_BIT]};
    assign coin_raw   = joy_sync[COIN_BIT];
    assign pause_rise = joy_sync[PAUSE_BIT] & ~pause_last;  // Board bit is active high

endmodule

// ==== rtl/cabinet_controls.sv ====
`timescale 1ns/10ps

// Cabinet-wide controls built from both players and the keys
// Coin, start and service merge, pause and layer toggles, soft reset
module cabinet_controls (
    input  logic                     clk_sys,
    input  logic                     rst,
    input  board_pkg::player_pair_t  start_raw [board_pkg::NUM_PLAYERS],
    input  board_pkg::player_pair_t  coin_raw,
    input  board_pkg::player_pair_t  pause_rise,
    input  logic                     service_sync,
    input  logic                     key_pause_rise,
    input  logic                     key_reset_rise,
    input  board_pkg::gfx_mask_t     key_gfx_rise,
    output board_pkg::player_pair_t  game_coin,
    output board_pkg::player_pair_t  game_start,
    output logic                     game_service,
    output logic                     game_pause,
    output board_pkg::gfx_mask_t     gfx_en,
    output logic                     soft_rst
);
    import board_pkg::*;

    player_pair_t start_any;
    logic         pause_req;  // Registered toggle requests
    gfx_mask_t    gfx_req;

    // Either player can press either start button
    always_comb begin
        start_any = '0;
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            start_any = start_any | start_raw[i];
        end
    end

    always_ff @(posedge clk_sys) begin
        game_coin  <= coin_raw ^ {2{INVERT_INPUTS}};
        game_start <= start_any ^ {2{INVERT_INPUTS}};
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_service <= INVERT_INPUTS;
            pause_req    <= 1'b0;
            gfx_req      <= '0;
            soft_rst     <= 1'b0;
        end else begin
            game_service <= service_sync ^ INVERT_INPUTS;
            pause_req    <= key_pause_rise | (|pause_rise);
            gfx_req      <= key_gfx_rise;
            soft_rst     <= key_reset_rise;
        end
    end

    // Toggle state
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause <= 1'b0;
            gfx_en     <= '1;  // All layers shown
        end else begin
            game_pause <= game_pause ^ pause_req;
            gfx_en     <= gfx_en ^ gfx_req;
        end
    end

    // Key edge detection upstream must give one-cycle requests
    a_soft_rst_pulse: assert property (
        @(posedge clk_sys) disable iff (rst) soft_rst |=> !soft_rst
    ) else $error("soft_rst held longer than one cycle");

endmodule

// ==== rtl/reset_sequencer.sv ====
`timescale 1ns/10ps

// Core and game reset sequencing
// Core hold after rst, then a game hold that any game reset cause restarts
// Active-low copies through two flops
module reset_sequencer (
    input  logic clk_sys,
    input  logic rst,
    input  logic downloading,
    input  logic rst_req,
    input  logic flip,
    input  logic soft_rst,
    output logic core_rst,
    output logic core_rst_n,
    output logic game_rst,
    output logic game_rst_n
);
    import board_pkg::*;

    reset_state_t         state, state_next;
    logic [RST_CNT_W-1:0] cnt, cnt_next;
    logic                 flip_last;
    logic                 game_cause;
    logic                 core_rst_pre_n;
    logic                 game_rst_pre_n;

    // Screen flip change restarts the game as well
    assign game_cause = downloading | rst_req | soft_rst | (flip != flip_last);

    always_comb begin
        state_next = state;
        cnt_next   = cnt + 1'b1;
        case (state)
            POWER_HOLD: begin
                if (&cnt) begin
                    state_next = GAME_HOLD;  // Counter wraps to zero for the game hold
                end
            end
            GAME_HOLD: begin
                if (game_cause) begin
                    cnt_next = '0;
                end else if (&cnt) begin
                    state_next = RUNNING;
                end
            end
            RUNNING: begin
                cnt_next = '0;
                if (game_cause) begin
                    state_next = GAME_HOLD;
                end
            end
            default: begin
                state_next = POWER_HOLD;
                cnt_next   = '0;
            end
        endcase
    end

    always_ff @(posedge clk_sys) begin
        flip_last <= flip;
        if (rst) begin
            state    <= POWER_HOLD;
            cnt      <= '0;
            core_rst <= 1'b1;
            game_rst <= 1'b1;
        end else begin
            state    <= state_next;
            cnt      <= cnt_next;
            core_rst <= (state_next == POWER_HOLD);
            game_rst <= (state_next != RUNNING);  // Also high through the core hold
        end
    end

    // Active-low copies two cycles behind
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            core_rst_pre_n <= 1'b0;
            core_rst_n     <= 1'b0;
            game_rst_pre_n <= 1'b0;
            game_rst_n     <= 1'b0;
        end else begin
            core_rst_pre_n <= ~core_rst;
            core_rst_n     <= core_rst_pre_n;
            game_rst_pre_n <= ~game_rst;
            game_rst_n     <= game_rst_pre_n;
        end
    end

    a_core_in_game: assert property (
        @(posedge clk_sys) core_rst |-> game_rst
    ) else $error("core_rst high without game_rst");

    a_core_n_delay: assert property (
        @(posedge clk_sys) core_rst |-> ##2 !core_rst_n
    ) else $error("core_rst_n released too early");

endmodule

// ==== rtl/board_top.sv ====
`timescale 1ns/10ps

// Player-input and reset section of the board wrapper
// Capture feeds one player port per joystick, cabinet controls merge them,
// reset sequencer runs alongside
module board_top (
    input  logic                     clk_sys,
    input  logic                     rst,
    input  board_pkg::board_joy_t    board_joystick1,
    input  board_pkg::board_joy_t    board_joystick2,
    input  logic                     rot_control,
    input  logic                     flip,
    input  logic                     downloading,
    input  logic                     rst_req,
    input  logic                     key_reset,
    input  logic                     key_pause,
    input  logic                     key_service,
    input  board_pkg::gfx_mask_t     key_gfx,
    output logic                     core_rst,
    output logic                     core_rst_n,
    output logic                     game_rst,
    output logic                     game_rst_n,
    output board_pkg::game_joy_t     game_joystick1,
    output board_pkg::game_joy_t     game_joystick2,
    output board_pkg::player_pair_t  game_coin,
    output board_pkg::player_pair_t  game_start,
    output logic                     game_service,
    output logic                     game_pause,
    output board_pkg::gfx_mask_t     gfx_en
);
    import board_pkg::*;

    board_joy_t   joy_sync  [NUM_PLAYERS];
    game_joy_t    game_joy  [NUM_PLAYERS];
    player_pair_t start_raw [NUM_PLAYERS];
    player_pair_t coin_raw;
    player_pair_t pause_rise;
    logic         service_sync;
    logic         key_pause_rise;
    logic         key_reset_rise;
    gfx_mask_t    key_gfx_rise;
    logic         soft_rst;

    board_input_capture u_capture (
        .clk_sys         ( clk_sys         ),
        .rst             ( rst             ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .key_pause       ( key_pause       ),
        .key_reset       ( key_reset       ),
        .key_service     ( key_service     ),
        .key_gfx         ( key_gfx         ),
        .joy_sync        ( joy_sync        ),
        .service_sync    ( service_sync    ),
        .key_pause_rise  ( key_pause_rise  ),
        .key_reset_rise  ( key_reset_rise  ),
        .key_gfx_rise    ( key_gfx_rise    )
    );

    for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_player
        player_port u_port (
            .clk_sys       ( clk_sys       ),
            .rst           ( rst           ),
            .rot_control   ( rot_control   ),
            .joy_sync      ( joy_sync[i]   ),
            .game_joystick ( game_joy[i]   ),
            .start_raw     ( start_raw[i]  ),
            .coin_raw      ( coin_raw[i]   ),
            .pause_rise    ( pause_rise[i] )
        );
    end

    assign game_joystick1 = game_joy[0];
    assign game_joystick2 = game_joy[1];

    cabinet_controls u_cabinet (
        .clk_sys        ( clk_sys        ),
        .rst            ( rst            ),
        .start_raw      ( start_raw      ),
        .coin_raw       ( coin_raw       ),
        .pause_rise     ( pause_rise     ),
        .service_sync   ( service_sync   ),
        .key_pause_rise ( key_pause_rise ),
        .key_reset_rise ( key_reset_rise ),
        .key_gfx_rise   ( key_gfx_rise   ),
        .game_coin      ( game_coin      ),
        .game_start     ( game_start     ),
        .game_service   ( game_service   ),
        .game_pause     ( game_pause     ),
        .gfx_en         ( gfx_en         ),
        .soft_rst       ( soft_rst       )
    );

    reset_sequencer u_reset (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .rst_req     ( rst_req     ),
        .flip        ( flip        ),
        .soft_rst    ( soft_rst    ),
        .core_rst    ( core_rst    ),
        .core_rst_n  ( core_rst_n  ),
        .game_rst    ( game_rst    ),
        .game_rst_n  ( game_rst_n  )
    );

endmodule

// ==== verif/tb_board.sv ====
`timescale 1ns/10ps

// Testbench for the player-input and reset section
// Xorshift stimulus, reference model on input history, compare tasks,
// reset edge monitor and watchdog
module tb_board;
    import board_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int HOLD_CYCLES  = 1 << RST_CNT_W;
    localparam int TOL          = 3;     // Reset edge window in cycles
    localparam int RAND_CYCLES  = 1500;
    localparam int HIST_DEPTH   = 6;     // Enough for the 4-cycle toggle path plus one
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * HOLD_CYCLES + 4 * RAND_CYCLES
                                  + 4 * (HOLD_CYCLES + 64) + 64;
    localparam longint WATCHDOG_NS = (TEST_CYCLES + 2000) * 10;

    localparam int MODE_JOY   = 0;
    localparam int MODE_PAUSE = 1;
    localparam int MODE_GFX   = 2;

    localparam int CAUSE_KEY  = 0;
    localparam int CAUSE_FLIP = 1;
    localparam int CAUSE_REQ  = 2;
    localparam int CAUSE_DL   = 3;

    logic         clk_sys;
    logic         rst;
    board_joy_t   board_joystick1;
    board_joy_t   board_joystick2;
    logic         rot_control;
    logic         flip;
    logic         downloading;
    logic         rst_req;
    logic         key_reset;
    logic         key_pause;
    logic         key_service;
    gfx_mask_t    key_gfx;
    logic         core_rst;
    logic         core_rst_n;
    logic         game_rst;
    logic         game_rst_n;
    game_joy_t    game_joystick1;
    game_joy_t    game_joystick2;
    player_pair_t game_coin;
    player_pair_t game_start;
    logic         game_service;
    logic         game_pause;
    gfx_mask_t    gfx_en;

    logic [31:0] rng_state;
    int          error_count;
    bit          model_on;
    bit          core_low_check;   // core_rst must stay low from here on

    // Reset monitor counting cycles on falling edges
    int          cycle;
    logic        core_last;
    logic        game_last;
    logic [1:0]  core_hist;        // [0] one cycle ago, [1] two cycles ago
    logic [1:0]  game_hist;
    int          core_fall;
    int          game_rise;
    int          game_fall;

    // Input history with the newest entry first
    board_joy_t  j1_q[$];
    board_joy_t  j2_q[$];
    logic        rot_q[$];
    logic        kp_q[$];
    logic        svc_q[$];
    gfx_mask_t   kg_q[$];
    logic        exp_pause;
    gfx_mask_t   exp_gfx;

    board_top dut (
        .clk_sys         ( clk_sys         ),
        .rst             ( rst             ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .rot_control     ( rot_control     ),
        .flip            ( flip            ),
        .downloading     ( downloading     ),
        .rst_req         ( rst_req         ),
        .key_reset       ( key_reset       ),
        .key_pause       ( key_pause       ),
        .key_service     ( key_service     ),
        .key_gfx         ( key_gfx         ),
        .core_rst        ( core_rst        ),
        .core_rst_n      ( core_rst_n      ),
        .game_rst        ( game_rst        ),
        .game_rst_n      ( game_rst_n      ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      ),
        .game_service    ( game_service    ),
        .game_pause      ( game_pause      ),
        .gfx_en          ( gfx_en          )
    );

    initial begin
        clk_sys = 1'b0;
        forever begin
            #5 clk_sys = ~clk_sys;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Quarter-turn direction swap, then active-low game side
    function automatic game_joy_t expected_joy(input board_joy_t raw, input logic rot);
        game_joy_t w;
        w = raw[GAME_JOY_W-1:0];
        if (rot) begin
            w[3] = raw[0];
            w[2] = raw[1];
            w[1] = raw[3];
            w[0] = raw[2];
        end
        return w ^ {GAME_JOY_W{INVERT_INPUTS}};
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_joy(input string what, input game_joy_t got, input game_joy_t exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pair(input string what, input player_pair_t got,
                              input player_pair_t exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_mask(input string what, input gfx_mask_t got, input gfx_mask_t exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cycles(input string what, input int got, input int lo, input int hi);
        if (got < lo || got > hi) begin
            error_count++;
            $display("FAIL %0t: %s took %0d cycles, expected %0d to %0d",
                     $time, what, got, lo, hi);
            abort_run();
        end
    endtask

    // Reset edges and the active-low copies
    always @(negedge clk_sys) begin
        cycle++;
        if (cycle >= 3) begin
            check_bit("core_rst_n", core_rst_n, ~core_hist[1]);
            check_bit("game_rst_n", game_rst_n, ~game_hist[1]);
        end
        if (core_last === 1'b1 && core_rst === 1'b0) core_fall = cycle;
        if (game_last === 1'b0 && game_rst === 1'b1) game_rise = cycle;
        if (game_last === 1'b1 && game_rst === 1'b0) game_fall = cycle;
        if (core_low_check) check_bit("core_rst", core_rst, 1'b0);
        core_hist = {core_hist[0], core_rst};
        game_hist = {game_hist[0], game_rst};
        core_last = core_rst;
        game_last = game_rst;
    end

    // Reference model for the data outputs
    always @(negedge clk_sys) begin : model
        logic         toggle;
        player_pair_t start_exp;
        j1_q.push_front(board_joystick1);
        j2_q.push_front(board_joystick2);
        rot_q.push_front(rot_control);
        kp_q.push_front(key_pause);
        svc_q.push_front(key_service);
        kg_q.push_front(key_gfx);
        if (j1_q.size() > HIST_DEPTH) begin
            void'(j1_q.pop_back());
            void'(j2_q.pop_back());
            void'(rot_q.pop_back());
            void'(kp_q.pop_back());
            void'(svc_q.pop_back());
            void'(kg_q.pop_back());
        end
        if (model_on && j1_q.size() == HIST_DEPTH) begin
            // Rising edge sampled 4 cycles back toggles now
            toggle = (kp_q[4] & ~kp_q[5])
                   | (j1_q[4][PAUSE_BIT] & ~j1_q[5][PAUSE_BIT])
                   | (j2_q[4][PAUSE_BIT] & ~j2_q[5][PAUSE_BIT]);
            exp_pause = exp_pause ^ toggle;
            exp_gfx   = exp_gfx ^ (kg_q[4] & ~kg_q[5]);
            start_exp = {j1_q[3][START2_BIT] | j2_q[3][START2_BIT],
                         j1_q[3][START1_BIT] | j2_q[3][START1_BIT]};
            // Rotation control is unsynchronized and acts at the output register
            check_joy("game_joystick1", game_joystick1, expected_joy(j1_q[3], rot_q[1]));
            check_joy("game_joystick2", game_joystick2, expected_joy(j2_q[3], rot_q[1]));
            check_pair("game_coin", game_coin,
                       {j2_q[3][COIN_BIT], j1_q[3][COIN_BIT]} ^ {2{INVERT_INPUTS}});
            check_pair("game_start", game_start, start_exp ^ {2{INVERT_INPUTS}});
            check_bit("game_service", game_service, svc_q[3] ^ INVERT_INPUTS);
            check_bit("game_pause", game_pause, exp_pause);
            check_mask("gfx_en", gfx_en, exp_gfx);
        end
    end

    task automatic check_reset_release(input int rel_cyc);
        int waited;
        waited = 0;
        while (game_fall == 0 && waited < 2 * HOLD_CYCLES + 64) begin
            @(posedge clk_sys);
            waited++;
        end
        if (game_fall == 0) begin
            $display("Reset release: game_rst never went low after rst was released");
            abort_run();
        end
        check_cycles("core_rst hold after rst", core_fall - rel_cyc,
                     HOLD_CYCLES - TOL, HOLD_CYCLES + TOL);
        check_cycles("game_rst hold after core_rst", game_fall - core_fall,
                     HOLD_CYCLES - TOL, HOLD_CYCLES + TOL);
        @(negedge clk_sys);
        check_bit("game_pause after reset", game_pause, 1'b0);
        check_mask("gfx_en after reset", gfx_en, '1);
        check_bit("game_service after reset", game_service, INVERT_INPUTS);
    endtask

    task automatic run_random(input int cycles, input int mode, input logic rot);
        logic [31:0] r;
        logic [31:0] w;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk_sys);
            r = next_rand();
            w = next_rand();
            rot_control <= rot;
            case (mode)
                MODE_JOY: begin
                    board_joystick1 <= w[15:0];
                    board_joystick2 <= w[31:16];
                    key_service     <= r[0];
                end
                MODE_PAUSE: begin  // Held levels toggle once per rise
                    if (r[2:0] == 3'd0) key_pause <= ~key_pause;
                    if (r[4:3] == 2'd0) board_joystick1 <= w[15:0];
                    if (r[6:5] == 2'd0) board_joystick2 <= w[31:16];
                end
                default: begin
                    if (r[1:0] == 2'd0) key_gfx <= w[3:0];
                end
            endcase
        end
    endtask

    task automatic quiet_inputs();
        @(posedge clk_sys);
        rot_control <= 1'b0;
        key_pause   <= 1'b0;
        key_service <= 1'b0;
        key_gfx     <= '0;
        board_joystick1 <= '0;
        board_joystick2 <= '0;
    endtask

    // One game reset cause, then the hold measured from the later of rise and cause end
    task automatic pulse_cause(input string what, input int kind, input int len,
                               input int rise_limit);
        int drive_cyc;
        int off_cyc;
        int start_rise;
        int waited;
        @(posedge clk_sys);
        drive_cyc  = cycle + 1;
        start_rise = game_rise;
        case (kind)
            CAUSE_KEY:  key_reset   <= 1'b1;
            CAUSE_FLIP: flip        <= ~flip;
            CAUSE_REQ:  rst_req     <= 1'b1;
            default:    downloading <= 1'b1;
        endcase
        repeat (len) @(posedge clk_sys);
        off_cyc = cycle + 1;
        key_reset   <= 1'b0;
        rst_req     <= 1'b0;
        downloading <= 1'b0;
        waited = 0;
        while ((game_rise == start_rise || game_fall < game_rise)
               && waited < HOLD_CYCLES + len + 64) begin
            @(posedge clk_sys);
            waited++;
        end
        if (game_rise == start_rise) begin
            $display("Game reset by %s: game_rst never went high", what);
            abort_run();
        end
        if (game_fall < game_rise) begin
            $display("Game reset by %s: game_rst never went low again", what);
            abort_run();
        end
        check_cycles({what, " game_rst rise"}, game_rise - drive_cyc, 0, rise_limit);
        check_cycles({what, " game_rst hold"},
                     game_fall - ((game_rise > off_cyc) ? game_rise : off_cyc),
                     HOLD_CYCLES - TOL, HOLD_CYCLES + TOL);
    endtask

    initial begin
        int rel_cyc;
        rng_state       = 32'h1aad8592;
        error_count     = 0;
        model_on        = 1'b0;
        core_low_check  = 1'b0;
        exp_pause       = 1'b0;
        exp_gfx         = '1;
        cycle           = 0;
        core_last       = 1'b1;
        game_last       = 1'b1;
        core_fall       = 0;
        game_rise       = 0;
        game_fall       = 0;
        rst             = 1'b1;
        board_joystick1 = '0;
        board_joystick2 = '0;
        rot_control     = 1'b0;
        flip            = 1'b0;
        downloading     = 1'b0;
        rst_req         = 1'b0;
        key_reset       = 1'b0;
        key_pause       = 1'b0;
        key_service     = 1'b0;
        key_gfx         = '0;

        repeat (RESET_CYCLES) @(posedge clk_sys);
        rst <= 1'b0;
        rel_cyc = cycle + 1;
        check_reset_release(rel_cyc);

        @(posedge clk_sys);
        model_on = 1'b1;
        run_random(RAND_CYCLES, MODE_JOY, 1'b0);
        run_random(RAND_CYCLES, MODE_JOY, 1'b1);
        run_random(RAND_CYCLES, MODE_PAUSE, 1'b0);
        run_random(RAND_CYCLES, MODE_GFX, 1'b0);
        quiet_inputs();
        repeat (8) @(posedge clk_sys);

        core_low_check = 1'b1;
        // Held key gives one soft_rst pulse after sync, edge and soft reset stages
        pulse_cause("key_reset", CAUSE_KEY, 3, 4);
        pulse_cause("flip", CAUSE_FLIP, 1, TOL);
        pulse_cause("rst_req", CAUSE_REQ, 1, TOL);
        pulse_cause("downloading", CAUSE_DL, 40, TOL);
        repeat (8) @(posedge clk_sys);

        if (error_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

endmodule

// ==== src.f ====
rtl/board_pkg.sv
rtl/board_input_capture.sv
rtl/player_port.sv
rtl/cabinet_controls.sv
rtl/reset_sequencer.sv
rtl/board_top.sv
verif/tb_board.sv
